/* k051960.f */
+incdir+source
source/k051960_pkg.sv
source/cpu_reg_decode.sv
source/video_timing.sv
source/irq_gen.sv
source/rom_readout.sv
source/k051960.sv
sim/k051960_assertions.sv
sim/k051960_checker.sv
sim/k051960_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the K051960 testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f k051960.f --top-module k051960_tb -o k051960_sim \
	> build.log 2>&1 && ./obj_dir/k051960_sim > sim.log 2>&1 \
	|| echo "Simulation finished: FAIL" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
exit 0

/* sim/k051960_assertions.sv */
// K051960 raster timing assertions
// Frame tick width and vertical counter range

`timescale 1ns/1ns
`include "k051960_consts.svh"

module k051960_assertions (
	input logic       clk_6M,
	input logic       RES_SYNC,
	input logic       hvot,
	input logic [8:0] row
);

	hvot_single: assert property (@(posedge clk_6M) disable iff (!RES_SYNC)
		!hvot |=> hvot)
		else $error("hvot held low for two cycles in a row");

	row_range: assert property (@(posedge clk_6M) disable iff (!RES_SYNC)
		(row >= `K_V_FIRST) && (row <= `K_V_LAST))
		else $error("row left the frame range");

endmodule

bind video_timing k051960_assertions u_assert (
	.clk_6M   (clk_6M),
	.RES_SYNC (RES_SYNC),
	.hvot     (hvot),
	.row      (row)
);

/* sim/k051960_checker.sv */
// K051960 checker
// Compares DUT outputs, watches frame tick and reset release, keeps the counts

`timescale 1ns/1ns
`include "k051960_consts.svh"

module k051960_checker (
	input logic        clk_6M,
	input logic        RES_SYNC,
	input logic [17:0] ca,
	input logic [7:0]  oc,
	input logic [7:0]  db_out,
	input logic        db_dir,
	input logic        irq,
	input logic        firq,
	input logic        nmi,
	input logic        hvot,
	input logic        p1h,
	input logic        p2h,
	input logic        rst
);
	localparam int LINE = int'(`K_H_LAST) - int'(`K_H_FIRST) + 1;
	localparam int FRAME = LINE * (int'(`K_V_LAST) - int'(`K_V_FIRST) + 1);
	// 8th vblank rise, plus one cycle for the shift register
	localparam int RST_CYC = (int'(`K_VBL_START) - int'(`K_V_FIRST)) * LINE
		+ (`K_RST_FRAMES - 1) * FRAME + 1;

	int cyc = 0;
	int err_cnt = 0;
	int test_cnt = 0;
	int hvot_cnt = 0;
	int last_low = 0;
	bit hvot_q = 1'b1;
	bit rst_seen = 1'b0;
	bit rst_bad = 1'b0;
	bit frames_seen = 1'b0;
	bit ph_bad = 1'b0;
	bit ph_done = 1'b0;
	logic [8:0] exp_h;

	// Rising edges since reset release
	always @(posedge clk_6M)
		if (RES_SYNC)
			cyc <= cyc + 1;

	function automatic int diff(string nm, string what, int exp, int act);
		if (exp != act) begin
			$display("Mismatch %s %s: expected %0h, actual %0h", nm, what, exp, act);
			return 1;
		end
		return 0;
	endfunction

	task automatic finish_test(string nm, int errs);
		test_cnt++;
		err_cnt += errs;
		$display("%s %s", (errs == 0) ? "passed" : "FAILED", nm);
	endtask

	task automatic check_rom(string nm, logic [17:0] exp_ca, logic [7:0] exp_oc);
		finish_test(nm, diff(nm, "ca", int'(exp_ca), int'(ca))
			+ diff(nm, "oc", int'(exp_oc), int'(oc)));
	endtask

	task automatic check_status(string nm, logic [7:0] exp_db);
		finish_test(nm, diff(nm, "db_out", int'(exp_db), int'(db_out))
			+ diff(nm, "db_dir", 1, int'(db_dir)));
	endtask

	// Expected pins as {nmi, firq, irq}
	task automatic check_lines(string nm, logic [2:0] exp);
		finish_test(nm, diff(nm, "{nmi,firq,irq}", int'(exp), int'({nmi, firq, irq})));
	endtask

	task automatic check_held(string nm, int cycles);
		int e;
		e = 0;
		repeat (cycles) begin
			@(negedge clk_6M);
			if (e == 0)
				e = diff(nm, "{nmi,firq,irq}", 7, int'({nmi, firq, irq}));
		end
		finish_test(nm, e);
	endtask

	task automatic note_failure(string nm, string msg);
		$display("Error in %s: %s", nm, msg);
		finish_test(nm, 1);
	endtask

	task automatic report_counts();
		$display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
	endtask

	always @(negedge clk_6M) begin
		if (RES_SYNC) begin
			// H counter restarts at K_H_FIRST on every line
			exp_h = `K_H_FIRST + 9'(cyc % LINE);
			if (!ph_done && !ph_bad)
				ph_bad = (diff("pixel_phase", "{p2h,p1h}", int'(exp_h[1:0]),
					int'({p2h, p1h})) != 0);
			if (!hvot) begin
				if (!hvot_q) begin
					$display("Error in frame_timing: hvot low for more than one cycle");
					err_cnt++;
				end else if (hvot_cnt == 0) begin
					finish_test("pixel_phase", int'(ph_bad));
					ph_done = 1'b1;
				end else if (hvot_cnt == 1) begin
					finish_test("frame_timing",
						diff("frame_timing", "hvot period", FRAME, cyc - last_low));
					frames_seen = 1'b1;
				end
				hvot_cnt++;
				last_low = cyc;
			end
			hvot_q = hvot;
			if (rst && !rst_seen) begin
				rst_seen = 1'b1;
				finish_test("reset_release", diff("reset_release", "rst rise cycle", RST_CYC, cyc));
			end else if (!rst && rst_seen && !rst_bad) begin
				rst_bad = 1'b1;
				$display("Error in reset_release: rst fell again after its release");
				err_cnt++;
			end
		end
	end

endmodule

/* sim/k051960_tb.sv */
// K051960 testbench
// Clock, reset, stimulus table, interrupt sequence and watchdog

`timescale 1ns/1ns
`include "k051960_consts.svh"

module k051960_tb;
	localparam int LINE = int'(`K_H_LAST) - int'(`K_H_FIRST) + 1;
	localparam int FRAME = LINE * (int'(`K_V_LAST) - int'(`K_V_FIRST) + 1);
	localparam int N = 11;

	logic        clk_6M;
	logic        RES_SYNC;
	logic [10:0] ab;
	logic [7:0]  db_in;
	logic        obcs;
	logic        nrd;
	logic [7:0]  db_out;
	logic        db_dir;
	logic [17:0] ca;
	logic [7:0]  oc;
	logic        irq;
	logic        firq;
	logic        nmi;
	logic        hvot;
	logic        p1h;
	logic        p2h;
	logic        rst;

	string       t_name [N];
	int          t_wait [N];
	logic [10:0] t_addr [N];
	logic [7:0]  t_data [N];
	bit          t_wr [N];
	bit          t_rd [N];
	logic [17:0] t_ca [N];
	logic [7:0]  t_oc [N];
	logic [7:0]  t_db [N];
	int          n_tab;
	int          seed;
	int          rnd;

	k051960 uut (.*);

	k051960_checker chk (.clk_6M(clk_6M), .RES_SYNC(RES_SYNC), .ca(ca), .oc(oc),
		.db_out(db_out), .db_dir(db_dir), .irq(irq), .firq(firq), .nmi(nmi),
		.hvot(hvot), .p1h(p1h), .p2h(p2h), .rst(rst));

	initial clk_6M = 1'b0;
	always #50 clk_6M = ~clk_6M;

	task automatic add_entry(string nm, int w, logic [10:0] a, logic [7:0] d, bit wr, bit rd,
		logic [17:0] c, logic [7:0] o, logic [7:0] db);
		t_name[n_tab] = nm;
		t_wait[n_tab] = w;
		t_addr[n_tab] = a;
		t_data[n_tab] = d;
		t_wr[n_tab] = wr;
		t_rd[n_tab] = rd;
		t_ca[n_tab] = c;
		t_oc[n_tab] = o;
		t_db[n_tab] = db;
		n_tab++;
	endtask

	// Random ROM-window read, bank 2'b10 / 8'h5A and OC 8'hED when readout is on
	task automatic add_rom_access(string nm, bit on);
		logic [10:0] a;
		rnd = $random(seed);
		a = {1'b1, rnd[9:0]};
		add_entry(nm, 0, a, 8'h00, 1'b0, 1'b0, on ? {2'b10, 8'h5A, a[9:2]} : 18'd0,
			on ? 8'hED : 8'h00, 8'h00);
	endtask

	task automatic apply_entry(int i);
		while (chk.cyc < t_wait[i])
			@(negedge clk_6M);
		ab = t_addr[i];
		db_in = t_data[i];
		nrd = ~t_wr[i];
		obcs = 1'b0;
		#25;
		if (t_rd[i])
			chk.check_status(t_name[i], t_db[i]);
		@(negedge clk_6M);
		obcs = 1'b1;
		nrd = 1'b1;
		if (!t_rd[i])
			chk.check_rom(t_name[i], t_ca[i], t_oc[i]);
	endtask

	task automatic cpu_write(logic [10:0] a, logic [7:0] d);
		ab = a;
		db_in = d;
		nrd = 1'b0;
		obcs = 1'b0;
		@(negedge clk_6M);
		obcs = 1'b1;
		nrd = 1'b1;
	endtask

	function automatic logic pin(int w);
		return (w == 0) ? irq : (w == 1) ? firq : nmi;
	endfunction

	// Enable one source, wait for its line, then acknowledge it
	task automatic irq_case(string nm, logic [7:0] en, int w, int limit);
		int n;
		logic [2:0] exp;
		n = 0;
		exp = 3'b111;
		exp[w] = 1'b0;
		cpu_write(11'd0, en);
		while (pin(w) && n < limit) begin
			@(negedge clk_6M);
			n++;
		end
		if (pin(w)) begin
			chk.note_failure(nm, "interrupt line stayed high past its deadline");
		end else begin
			repeat (20) @(negedge clk_6M);
			chk.check_lines(nm, exp);
			cpu_write(11'd0, 8'h00);
			@(negedge clk_6M);
			chk.check_lines({nm, "_ack"}, 3'b111);
		end
	endtask

	initial begin
		seed = 87762;
		n_tab = 0;
		RES_SYNC = 1'b0;
		obcs = 1'b1;
		nrd = 1'b1;
		ab = 11'd0;
		db_in = 8'h00;
		add_entry("status_blank", 0, 11'd0, 8'h00, 1'b0, 1'b1, 18'd0, 8'h00, 8'h00);
		add_entry("wr_reg2", 0, 11'd2, 8'h5A, 1'b1, 1'b0, 18'd0, 8'h00, 8'h00);
		add_entry("wr_reg3", 0, 11'd3, 8'hB6, 1'b1, 1'b0, 18'd0, 8'h00, 8'h00);
		add_entry("wr_reg4", 0, 11'd4, 8'h03, 1'b1, 1'b0, 18'd0, 8'h00, 8'h00);
		add_entry("rom_read_on", 0, 11'd0, 8'h20, 1'b1, 1'b0, {2'b10, 8'h5A, 8'h00}, 8'hED, 8'h00);
		add_rom_access("rom_access_a", 1'b1);
		add_rom_access("rom_access_b", 1'b1);
		add_entry("rom_read_off", 0, 11'd0, 8'h00, 1'b1, 1'b0, 18'd0, 8'h00, 8'h00);
		add_rom_access("rom_access_off", 1'b0);
		add_entry("status_active", (int'(`K_VBL_END) - int'(`K_V_FIRST)) * LINE + 8,
			11'd0, 8'h00, 1'b0, 1'b1, 18'd0, 8'h00, 8'h01);
		add_entry("status_vblank", (int'(`K_VBL_START) - int'(`K_V_FIRST)) * LINE + 8,
			11'd0, 8'h00, 1'b0, 1'b1, 18'd0, 8'h00, 8'h00);
		repeat (8) @(negedge clk_6M);
		RES_SYNC = 1'b1;
		for (int i = 0; i < n_tab; i++)
			apply_entry(i);
		chk.check_held("irq_disabled", 40 * LINE);
		irq_case("irq_enabled", 8'h01, 0, FRAME + 2);
		irq_case("firq_enabled", 8'h02, 1, 2 * LINE + 2);
		irq_case("nmi_enabled", 8'h04, 2, 32 * LINE + 2);
		while (!(chk.rst_seen && chk.frames_seen))
			@(negedge clk_6M);
		chk.report_counts();
		if (chk.err_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// Ten frames plus the table is far more than the run needs
	initial begin
		#((10 * FRAME + N) * 100);
		$display("Timeout: the run did not complete in the allowed time");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* source/cpu_reg_decode.sv */
// K051960 CPU register window
// Decodes offsets 0, 2, 3, 4 and holds the control registers

`timescale 1ns/1ns
`include "k051960_consts.svh"

module cpu_reg_decode (
	input  logic                      clk_6M,
	input  logic                      RES_SYNC,
	input  logic [`K_AB_W-1:0]        ab,
	input  k051960_pkg::cpu_byte_t    db_in,
	input  logic                      obcs,
	input  logic                      nrd,
	output k051960_pkg::reg0_t        reg0,
	output k051960_pkg::rom_bank_t    rom_bank,
	output k051960_pkg::oc_bits_t     oc_bits,
	output logic                      reg0_rd
);
	import k051960_pkg::*;

	logic       reg_sel;
	logic [2:0] offset;
	logic       wr;
	logic       reg0_wr;
	logic       reg2_wr;
	logic       reg3_wr;
	logic       reg4_wr;
	cpu_byte_t  reg2;
	cpu_byte_t  reg3;
	logic [1:0] reg4;

	// Window is ab[10] low with ab[9:3] all zero
	assign reg_sel = ~obcs & ~ab[`K_AB_W-1] & (ab[`K_AB_W-2:3] == '0);
	assign offset = ab[2:0];
	assign wr = reg_sel & ~nrd;

	assign reg0_wr = wr & (offset == `K_REG0);
	assign reg2_wr = wr & (offset == `K_REG2);
	assign reg3_wr = wr & (offset == `K_REG3);
	assign reg4_wr = wr & (offset == `K_REG4);

	// Status read of reg 0
	assign reg0_rd = reg_sel & nrd & (offset == `K_REG0);

	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			reg0 <= '0;
			reg2 <= '0;
			reg3 <= '0;
			reg4 <= '0;
		end else begin
			if (reg0_wr) begin
				reg0.rom_read <= db_in[`K_R0_ROM_READ];
				reg0.irq_en <= db_in[`K_R0_IRQ_EN];
				reg0.firq_en <= db_in[`K_R0_FIRQ_EN];
				reg0.nmi_en <= db_in[`K_R0_NMI_EN];
			end
			if (reg2_wr)
				reg2 <= db_in;
			if (reg3_wr)
				reg3 <= db_in;
			// Only two bits live in reg 4
			if (reg4_wr)
				reg4 <= db_in[1:0];
		end
	end

	assign rom_bank.bank_hi = reg3[1:0];
	assign rom_bank.bank_mid = reg2;
	assign oc_bits = {reg4, reg3[7:2]};

endmodule

/* source/irq_gen.sv */
// K051960 interrupt flags
// IRQ on vblank, FIRQ on odd lines, NMI every 32 lines

`timescale 1ns/1ns

module irq_gen (
	input  logic                    clk_6M,
	input  logic                    RES_SYNC,
	input  k051960_pkg::raster_t    row,
	input  logic                    line_end,
	input  logic                    vblank,
	input  k051960_pkg::reg0_t      reg0,
	output logic                    irq,
	output logic                    firq,
	output logic                    nmi
);

	logic vblank_q;
	logic irq_set;
	logic firq_set;
	logic nmi_set;
	logic irq_flag;
	logic firq_flag;
	logic nmi_flag;

	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC)
			vblank_q <= 1'b1;
		else
			vblank_q <= vblank;
	end

	assign irq_set = vblank & ~vblank_q;
	assign firq_set = line_end & row[0];
	// Rows ending in 5'b11111 come round every 32 lines
	assign nmi_set = line_end & (&row[4:0]);

	// A zero enable bit acts as the acknowledge and holds the flag off
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			irq_flag <= 1'b0;
			firq_flag <= 1'b0;
			nmi_flag <= 1'b0;
		end else begin
			if (!reg0.irq_en)
				irq_flag <= 1'b0;
			else if (irq_set)
				irq_flag <= 1'b1;
			if (!reg0.firq_en)
				firq_flag <= 1'b0;
			else if (firq_set)
				firq_flag <= 1'b1;
			if (!reg0.nmi_en)
				nmi_flag <= 1'b0;
			else if (nmi_set)
				nmi_flag <= 1'b1;
		end
	end

	assign irq = ~irq_flag;
	assign firq = ~firq_flag;
	assign nmi = ~nmi_flag;

endmodule

/* source/k051960.sv */
// K051960 sprite controller, control side
// Register window, raster timing, interrupts and ROM readout

`timescale 1ns/1ns
`include "k051960_consts.svh"

module k051960 (
	input  logic                      clk_6M,
	input  logic                      RES_SYNC,
	input  logic [`K_AB_W-1:0]        ab,
	input  k051960_pkg::cpu_byte_t    db_in,
	input  logic                      obcs,
	input  logic                      nrd,
	output k051960_pkg::cpu_byte_t    db_out,
	output logic                      db_dir,
	output logic [`K_CA_W-1:0]        ca,
	output logic [`K_OC_W-1:0]        oc,
	output logic                      irq,
	output logic                      firq,
	output logic                      nmi,
	output logic                      hvot,
	output logic                      p1h,
	output logic                      p2h,
	output logic                      rst
);
	import k051960_pkg::*;

	reg0_t     reg0;
	rom_bank_t rom_bank;
	oc_bits_t  oc_bits;
	logic      reg0_rd;
	raster_t   row;
	logic      line_end;
	logic      vblank;

	cpu_reg_decode u_decode (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.ab       (ab),
		.db_in    (db_in),
		.obcs     (obcs),
		.nrd      (nrd),
		.reg0     (reg0),
		.rom_bank (rom_bank),
		.oc_bits  (oc_bits),
		.reg0_rd  (reg0_rd)
	);

	video_timing u_timing (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.row      (row),
		.line_end (line_end),
		.vblank   (vblank),
		.hvot     (hvot),
		.p1h      (p1h),
		.p2h      (p2h),
		.rst      (rst)
	);

	irq_gen u_irq (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.row      (row),
		.line_end (line_end),
		.vblank   (vblank),
		.reg0     (reg0),
		.irq      (irq),
		.firq     (firq),
		.nmi      (nmi)
	);

	rom_readout u_rom (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.ab       (ab),
		.obcs     (obcs),
		.reg0     (reg0),
		.rom_bank (rom_bank),
		.oc_bits  (oc_bits),
		.reg0_rd  (reg0_rd),
		.vblank   (vblank),
		.ca       (ca),
		.oc       (oc),
		.db_out   (db_out),
		.db_dir   (db_dir)
	);

endmodule

/* source/k051960_consts.svh */
// K051960 sprite controller constants
// Counter limits, register offsets, reg0 bit positions and bus widths

`ifndef K051960_CONSTS_SVH
`define K051960_CONSTS_SVH

// Horizontal counter, 384 pixels per line
`define K_H_FIRST 9'h020
`define K_H_LAST 9'h19F

// Vertical counter, 264 lines per frame
`define K_V_FIRST 9'h0F8
`define K_V_LAST 9'h1FF

// Blank from line 1F0 up to (not including) line 110
`define K_VBL_START 9'h1F0
`define K_VBL_END 9'h110

// Offsets inside the register window
`define K_REG0 3'd0
`define K_REG2 3'd2
`define K_REG3 3'd3
`define K_REG4 3'd4

// Reg 0 data bits
`define K_R0_IRQ_EN 0
`define K_R0_FIRQ_EN 1
`define K_R0_NMI_EN 2
`define K_R0_ROM_READ 5

// Frames of vblank before RST is released
`define K_RST_FRAMES 8

`define K_AB_W 11
`define K_DB_W 8
`define K_CA_W 18
`define K_OC_W 8

`endif

/* source/k051960_pkg.sv */
// K051960 shared types
// Raster values, CPU bytes and the register fields used across the chip

`include "k051960_consts.svh"

package k051960_pkg;

	// Raster counter value, both H and V
	typedef logic [8:0] raster_t;

	typedef logic [`K_DB_W-1:0] cpu_byte_t;

	// Control bits written through reg 0
	typedef struct packed {
		logic rom_read;
		logic irq_en;
		logic firq_en;
		logic nmi_en;
	} reg0_t;

	// Upper part of the ROM readout address
	typedef struct packed {
		logic [1:0]   bank_hi;
		logic [7:0]   bank_mid;
	} rom_bank_t;

	// Attribute bits shown on OC during readout
	typedef logic [`K_OC_W-1:0] oc_bits_t;

endpackage

/* source/rom_readout.sv */
// K051960 graphics ROM readout path
// CPU-side ROM address latch, CA/OC muxes and the status byte

`timescale 1ns/1ns
`include "k051960_consts.svh"

module rom_readout (
	input  logic                      clk_6M,
	input  logic                      RES_SYNC,
	input  logic [`K_AB_W-1:0]        ab,
	input  logic                      obcs,
	input  k051960_pkg::reg0_t        reg0,
	input  k051960_pkg::rom_bank_t    rom_bank,
	input  k051960_pkg::oc_bits_t     oc_bits,
	input  logic                      reg0_rd,
	input  logic                      vblank,
	output logic [`K_CA_W-1:0]        ca,
	output logic [`K_OC_W-1:0]        oc,
	output k051960_pkg::cpu_byte_t    db_out,
	output logic                      db_dir
);

	logic       rom_sel;
	logic [7:0] addr_lat;

	// ROM window is ab[10] high
	assign rom_sel = ~obcs & ab[`K_AB_W-1];

	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC)
			addr_lat <= '0;
		else if (rom_sel)
			addr_lat <= ab[9:2];
	end

	assign ca = reg0.rom_read ? {rom_bank.bank_hi, rom_bank.bank_mid, addr_lat} : '0;
	assign oc = reg0.rom_read ? oc_bits : '0;

	// Status byte, bit 0 is the inverted blank
	assign db_out = reg0_rd ? {7'd0, ~vblank} : '0;
	assign db_dir = reg0_rd;

endmodule

/* source/video_timing.sv */
// K051960 raster timing
// H/V counters, vblank, frame tick and the delayed reset release

`timescale 1ns/1ns
`include "k051960_consts.svh"

module video_timing (
	input  logic                    clk_6M,
	input  logic                    RES_SYNC,
	output k051960_pkg::raster_t    row,
	output logic                    line_end,
	output logic                    vblank,
	output logic                    hvot,
	output logic                    p1h,
	output logic                    p2h,
	output logic                    rst
);
	import k051960_pkg::*;

	raster_t                  hcnt;
	logic                     frame_end;
	logic                     vblank_q;
	logic                     vbl_rise;
	logic [`K_RST_FRAMES-1:0] rst_sr;

	assign line_end = (hcnt == `K_H_LAST);
	assign frame_end = line_end & (row == `K_V_LAST);

	// H counter, reloads after the last pixel
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC)
			hcnt <= `K_H_FIRST;
		else if (line_end)
			hcnt <= `K_H_FIRST;
		else
			hcnt <= hcnt + 9'd1;
	end

	// V counter steps once per line
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC)
			row <= `K_V_FIRST;
		else if (frame_end)
			row <= `K_V_FIRST;
		else if (line_end)
			row <= row + 9'd1;
	end

	// Blank wraps around the end of the frame
	assign vblank = (row >= `K_VBL_START) || (row < `K_VBL_END);

	// Frame sync, low on the very last cycle
	assign hvot = ~frame_end;

	assign p1h = hcnt[0];
	assign p2h = hcnt[1];

	// vblank is already high out of reset, so no edge is seen there
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC)
			vblank_q <= 1'b1;
		else
			vblank_q <= vblank;
	end

	assign vbl_rise = vblank & ~vblank_q;

	// One stage per frame
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC)
			rst_sr <= '0;
		else if (vbl_rise)
			rst_sr <= {rst_sr[`K_RST_FRAMES-2:0], 1'b1};
	end

	assign rst = rst_sr[`K_RST_FRAMES-1];

endmodule
